//--- verilog/cce_msg_pkg.sv
// shared widths, credit limit and message encodings for the CCE message unit
// memory, LCE request, LCE command, LCE response, coherence state and mode enums
package cce_msg_pkg;

  // address and block geometry
  localparam int PADDR_W        = 32;
  localparam int BLOCK_W        = 64;
  localparam int LG_BLOCK_BYTES = 3;

  // LCE population and message fields
  localparam int NUM_LCE   = 4;
  localparam int LCE_ID_W  = 2;
  localparam int CCE_ID_W  = 2;
  localparam int WAY_W     = 3;
  localparam int SIZE_W    = 3;

  // memory flow control
  localparam int MEM_CREDITS = 4;
  localparam int CREDIT_W    = 3;

  // invalidation ack tracking
  localparam int INV_CNT_W = 3;

  typedef enum logic [1:0] {
    e_mem_msg_rd    = 2'd0,
    e_mem_msg_uc_rd = 2'd1,
    e_mem_msg_uc_wr = 2'd2
  } mem_msg_e;

  typedef enum logic [1:0] {
    e_lce_req_rd    = 2'd0,
    e_lce_req_uc_rd = 2'd1,
    e_lce_req_uc_wr = 2'd2
  } lce_req_e;

  typedef enum logic [1:0] {
    e_lce_cmd_data       = 2'd0,
    e_lce_cmd_uc_data    = 2'd1,
    e_lce_cmd_uc_st_done = 2'd2,
    e_lce_cmd_inv        = 2'd3
  } lce_cmd_e;

  // only inv_ack is consumed here, coh_ack belongs to the dropped ack path
  typedef enum logic [1:0] {
    e_lce_resp_inv_ack = 2'd0,
    e_lce_resp_coh_ack = 2'd1
  } lce_resp_e;

  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2,
    e_coh_m = 2'd3
  } coh_state_e;

  typedef enum logic {
    e_cce_mode_uncached = 1'b0,
    e_cce_mode_normal   = 1'b1
  } cce_mode_e;

endpackage

//--- verilog/cce_mode_ctrl.sv
// memory credit counter and CCE mode register
// mode follows the configured mode only while no memory response is outstanding
`timescale 1ns/1ps

module cce_mode_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  cce_msg_pkg::cce_mode_e cfg_mode_i,
  input  logic                   mem_cmd_sent_i,
  input  logic                   mem_resp_pop_i,
  output cce_msg_pkg::cce_mode_e mode_o,
  output logic                   credit_free_o
);

  import cce_msg_pkg::*;

  // outstanding memory responses
  logic [CREDIT_W-1:0] credit_cnt;
  cce_mode_e           mode_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt <= '0;
      mode_r     <= e_cce_mode_uncached;
    end else begin
      // send and pop in one cycle cancel out
      if (mem_cmd_sent_i & ~mem_resp_pop_i) begin
        credit_cnt <= credit_cnt + 1'b1;
      end else if (mem_resp_pop_i & ~mem_cmd_sent_i) begin
        credit_cnt <= credit_cnt - 1'b1;
      end
      // switch only with nothing in flight
      if (credit_cnt == '0) begin
        mode_r <= cfg_mode_i;
      end
    end
  end

  assign credit_free_o = (credit_cnt < CREDIT_W'(MEM_CREDITS));
  assign mode_o        = mode_r;

endmodule

//--- verilog/cce_req_issue.sv
// LCE request to memory command translation
// uncached requests in any mode, cached reads only in normal mode
`timescale 1ns/1ps

module cce_req_issue (
  input  cce_msg_pkg::cce_mode_e              mode_i,
  input  cce_msg_pkg::cce_mode_e              cfg_mode_i,
  input  logic                                credit_free_i,
  input  logic                                lce_req_v_i,
  input  cce_msg_pkg::lce_req_e               lce_req_type_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]    lce_req_src_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]     lce_req_addr_i,
  input  logic [cce_msg_pkg::SIZE_W-1:0]      lce_req_size_i,
  input  logic [cce_msg_pkg::BLOCK_W-1:0]     lce_req_data_i,
  output logic                                lce_req_yumi_o,
  output logic                                mem_cmd_v_o,
  output cce_msg_pkg::mem_msg_e               mem_cmd_type_o,
  output logic [cce_msg_pkg::PADDR_W-1:0]     mem_cmd_addr_o,
  output logic [cce_msg_pkg::SIZE_W-1:0]      mem_cmd_size_o,
  output logic [cce_msg_pkg::LCE_ID_W-1:0]    mem_cmd_lce_id_o,
  output logic                                mem_cmd_uncached_o,
  output logic [cce_msg_pkg::BLOCK_W-1:0]     mem_cmd_data_o,
  input  logic                                mem_cmd_ready_i
);

  import cce_msg_pkg::*;

  logic normal;
  logic uc_open;
  logic can_send;

  // uncached mode stops issuing once normal mode is requested so the switch can drain
  assign normal   = (mode_i == e_cce_mode_normal);
  assign uc_open  = normal | (cfg_mode_i != e_cce_mode_normal);
  assign can_send = lce_req_v_i & credit_free_i & mem_cmd_ready_i;

  always_comb begin
    mem_cmd_v_o        = 1'b0;
    mem_cmd_type_o     = e_mem_msg_uc_rd;
    mem_cmd_addr_o     = lce_req_addr_i;
    mem_cmd_size_o     = lce_req_size_i;
    mem_cmd_lce_id_o   = lce_req_src_i;
    mem_cmd_uncached_o = 1'b1;
    mem_cmd_data_o     = '0;
    case (lce_req_type_i)
      e_lce_req_uc_rd: begin
        mem_cmd_v_o = can_send & uc_open;
      end
      e_lce_req_uc_wr: begin
        mem_cmd_v_o    = can_send & uc_open;
        mem_cmd_type_o = e_mem_msg_uc_wr;
        mem_cmd_data_o = lce_req_data_i;
      end
      e_lce_req_rd: begin
        // cached fill, block aligned; stalls on the port in uncached mode
        mem_cmd_v_o        = can_send & normal;
        mem_cmd_type_o     = e_mem_msg_rd;
        mem_cmd_addr_o     = {lce_req_addr_i[PADDR_W-1:LG_BLOCK_BYTES], {LG_BLOCK_BYTES{1'b0}}};
        mem_cmd_uncached_o = 1'b0;
      end
      default: begin
      end
    endcase
    // pop in the same cycle the command goes out
    lce_req_yumi_o = mem_cmd_v_o;
  end

endmodule

//--- verilog/cce_resp_forward.sv
// memory response to LCE command forwarding
// also arbitrates the LCE command port, invalidations take it when no response forwards
`timescale 1ns/1ps

module cce_resp_forward (
  input  cce_msg_pkg::cce_mode_e              mode_i,
  input  logic [cce_msg_pkg::CCE_ID_W-1:0]    cce_id_i,
  input  logic                                mem_resp_v_i,
  input  cce_msg_pkg::mem_msg_e               mem_resp_type_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]     mem_resp_addr_i,
  input  logic [cce_msg_pkg::SIZE_W-1:0]      mem_resp_size_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]    mem_resp_lce_id_i,
  input  logic [cce_msg_pkg::WAY_W-1:0]       mem_resp_way_i,
  input  cce_msg_pkg::coh_state_e             mem_resp_state_i,
  input  logic [cce_msg_pkg::BLOCK_W-1:0]     mem_resp_data_i,
  output logic                                mem_resp_yumi_o,
  output logic                                lce_cmd_v_o,
  output cce_msg_pkg::lce_cmd_e               lce_cmd_type_o,
  output logic [cce_msg_pkg::LCE_ID_W-1:0]    lce_cmd_dst_o,
  output logic [cce_msg_pkg::CCE_ID_W-1:0]    lce_cmd_src_o,
  output logic [cce_msg_pkg::PADDR_W-1:0]     lce_cmd_addr_o,
  output logic [cce_msg_pkg::SIZE_W-1:0]      lce_cmd_size_o,
  output logic [cce_msg_pkg::WAY_W-1:0]       lce_cmd_way_o,
  output cce_msg_pkg::coh_state_e             lce_cmd_state_o,
  output logic [cce_msg_pkg::BLOCK_W-1:0]     lce_cmd_data_o,
  input  logic                                lce_cmd_ready_i,
  input  logic                                inv_cmd_v_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]    inv_dst_i,
  input  logic [cce_msg_pkg::WAY_W-1:0]       inv_way_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]     inv_addr_i,
  output logic                                inv_grant_o
);

  import cce_msg_pkg::*;

  // a response wants the port this cycle
  logic fwd_v;

  always_comb begin
    fwd_v = 1'b0;
    // invalidate fields by default, no size and no data
    lce_cmd_type_o  = e_lce_cmd_inv;
    lce_cmd_dst_o   = inv_dst_i;
    lce_cmd_src_o   = cce_id_i;
    lce_cmd_addr_o  = inv_addr_i;
    lce_cmd_size_o  = '0;
    lce_cmd_way_o   = inv_way_i;
    lce_cmd_state_o = e_coh_i;
    lce_cmd_data_o  = '0;
    if (mem_resp_v_i) begin
      case (mem_resp_type_i)
        e_mem_msg_uc_rd: begin
          fwd_v          = 1'b1;
          lce_cmd_type_o = e_lce_cmd_uc_data;
          lce_cmd_size_o = mem_resp_size_i;
          lce_cmd_data_o = mem_resp_data_i;
        end
        e_mem_msg_uc_wr: begin
          // store done carries no data
          fwd_v          = 1'b1;
          lce_cmd_type_o = e_lce_cmd_uc_st_done;
        end
        e_mem_msg_rd: begin
          // cached fills wait for normal mode
          if (mode_i == e_cce_mode_normal) begin
            fwd_v           = 1'b1;
            lce_cmd_type_o  = e_lce_cmd_data;
            lce_cmd_size_o  = mem_resp_size_i;
            lce_cmd_way_o   = mem_resp_way_i;
            lce_cmd_state_o = mem_resp_state_i;
            lce_cmd_data_o  = mem_resp_data_i;
          end
        end
        default: begin
        end
      endcase
    end
    if (fwd_v) begin
      lce_cmd_dst_o  = mem_resp_lce_id_i;
      lce_cmd_addr_o = mem_resp_addr_i;
    end
    mem_resp_yumi_o = fwd_v & lce_cmd_ready_i;
    inv_grant_o     = ~fwd_v & lce_cmd_ready_i;
    lce_cmd_v_o     = mem_resp_yumi_o | (inv_grant_o & inv_cmd_v_i);
  end

endmodule

//--- verilog/cce_inv_engine.sv
// invalidation engine: idle, send and wait FSM
// lowest-id sharer pick, per-sharer way table, inv_ack up/down counter
`timescale 1ns/1ps

module cce_inv_engine (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  cce_msg_pkg::cce_mode_e                                 mode_i,
  input  logic                                                   inv_v_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]                        inv_addr_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]                       inv_req_lce_i,
  input  logic [cce_msg_pkg::NUM_LCE-1:0]                        sharers_hits_i,
  input  logic [cce_msg_pkg::NUM_LCE-1:0][cce_msg_pkg::WAY_W-1:0] sharers_ways_i,
  input  logic                                                   inv_grant_i,
  input  logic                                                   lce_resp_v_i,
  input  cce_msg_pkg::lce_resp_e                                 lce_resp_type_i,
  output logic                                                   inv_cmd_v_o,
  output logic [cce_msg_pkg::LCE_ID_W-1:0]                       inv_dst_o,
  output logic [cce_msg_pkg::WAY_W-1:0]                          inv_way_o,
  output logic [cce_msg_pkg::PADDR_W-1:0]                        inv_addr_o,
  output logic                                                   lce_resp_yumi_o,
  output logic                                                   busy_o
);

  import cce_msg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_SEND = 2'd1,
    ST_WAIT = 2'd2
  } inv_state_e;

  inv_state_e                     state_r;
  logic [INV_CNT_W-1:0]           ack_cnt_r;
  logic [PADDR_W-1:0]             addr_r;
  logic [NUM_LCE-1:0]             mask_r;
  logic [NUM_LCE-1:0]             mask_nxt;
  logic [NUM_LCE-1:0][WAY_W-1:0]  ways_r;
  logic [LCE_ID_W-1:0]            pe_id;
  logic                           pe_v;
  logic                           start;
  logic                           send;
  logic                           ack;

  // lowest set bit of the remaining sharers
  always_comb begin
    pe_id = '0;
    for (int i = NUM_LCE - 1; i >= 0; i--) begin
      if (mask_r[i]) begin
        pe_id = LCE_ID_W'(i);
      end
    end
  end

  assign pe_v     = |mask_r;
  assign mask_nxt = mask_r & ~(NUM_LCE'(1) << pe_id);
  assign start    = (state_r == ST_IDLE) & inv_v_i & (mode_i == e_cce_mode_normal);
  // a send needs the port, a held grant keeps the current sharer
  assign send     = (state_r == ST_SEND) & pe_v & inv_grant_i;
  // acks drain whenever the engine is active
  assign ack      = busy_o & lce_resp_v_i & (lce_resp_type_i == e_lce_resp_inv_ack);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= ST_IDLE;
      ack_cnt_r <= '0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (start) begin
            state_r <= ST_SEND;
          end
        end
        ST_SEND: begin
          // empty mask falls straight through to wait
          if (~pe_v | (send & (mask_nxt == '0))) begin
            state_r <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (ack_cnt_r == '0) begin
            state_r <= ST_IDLE;
          end
        end
        default: begin
          state_r <= ST_IDLE;
        end
      endcase
      if (send & ~ack) begin
        ack_cnt_r <= ack_cnt_r + 1'b1;
      end else if (ack & ~send) begin
        ack_cnt_r <= ack_cnt_r - 1'b1;
      end
    end
  end

  // capture on start, requester excluded from the sharer set
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_r <= inv_addr_i;
      mask_r <= sharers_hits_i & ~(NUM_LCE'(1) << inv_req_lce_i);
      ways_r <= sharers_ways_i;
    end else if (send) begin
      mask_r <= mask_nxt;
    end
  end

  assign inv_cmd_v_o     = (state_r == ST_SEND) & pe_v;
  assign inv_dst_o       = pe_id;
  assign inv_way_o       = ways_r[pe_id];
  assign inv_addr_o      = addr_r;
  assign lce_resp_yumi_o = ack;
  assign busy_o          = (state_r != ST_IDLE);

endmodule

//--- verilog/cce_msg_top.sv
// CCE message unit top level
// mode and credit control, request issue, response forward and invalidation engine
`timescale 1ns/1ps

module cce_msg_top (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  cce_msg_pkg::cce_mode_e                                 cfg_mode_i,
  input  logic [cce_msg_pkg::CCE_ID_W-1:0]                       cce_id_i,
  // LCE request, valid then yumi
  input  logic                                                   lce_req_v_i,
  input  cce_msg_pkg::lce_req_e                                  lce_req_type_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]                       lce_req_src_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]                        lce_req_addr_i,
  input  logic [cce_msg_pkg::SIZE_W-1:0]                         lce_req_size_i,
  input  logic [cce_msg_pkg::BLOCK_W-1:0]                        lce_req_data_i,
  output logic                                                   lce_req_yumi_o,
  // LCE response, only inv_ack is consumed
  input  logic                                                   lce_resp_v_i,
  input  cce_msg_pkg::lce_resp_e                                 lce_resp_type_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]                       lce_resp_src_i,
  output logic                                                   lce_resp_yumi_o,
  // LCE command, ready then valid
  output logic                                                   lce_cmd_v_o,
  output cce_msg_pkg::lce_cmd_e                                  lce_cmd_type_o,
  output logic [cce_msg_pkg::LCE_ID_W-1:0]                       lce_cmd_dst_o,
  output logic [cce_msg_pkg::CCE_ID_W-1:0]                       lce_cmd_src_o,
  output logic [cce_msg_pkg::PADDR_W-1:0]                        lce_cmd_addr_o,
  output logic [cce_msg_pkg::SIZE_W-1:0]                         lce_cmd_size_o,
  output logic [cce_msg_pkg::WAY_W-1:0]                          lce_cmd_way_o,
  output cce_msg_pkg::coh_state_e                                lce_cmd_state_o,
  output logic [cce_msg_pkg::BLOCK_W-1:0]                        lce_cmd_data_o,
  input  logic                                                   lce_cmd_ready_i,
  // memory command, ready then valid
  output logic                                                   mem_cmd_v_o,
  output cce_msg_pkg::mem_msg_e                                  mem_cmd_type_o,
  output logic [cce_msg_pkg::PADDR_W-1:0]                        mem_cmd_addr_o,
  output logic [cce_msg_pkg::SIZE_W-1:0]                         mem_cmd_size_o,
  output logic [cce_msg_pkg::LCE_ID_W-1:0]                       mem_cmd_lce_id_o,
  output logic                                                   mem_cmd_uncached_o,
  output logic [cce_msg_pkg::BLOCK_W-1:0]                        mem_cmd_data_o,
  input  logic                                                   mem_cmd_ready_i,
  // memory response, valid then yumi
  input  logic                                                   mem_resp_v_i,
  input  cce_msg_pkg::mem_msg_e                                  mem_resp_type_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]                        mem_resp_addr_i,
  input  logic [cce_msg_pkg::SIZE_W-1:0]                         mem_resp_size_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]                       mem_resp_lce_id_i,
  input  logic [cce_msg_pkg::WAY_W-1:0]                          mem_resp_way_i,
  input  cce_msg_pkg::coh_state_e                                mem_resp_state_i,
  input  logic [cce_msg_pkg::BLOCK_W-1:0]                        mem_resp_data_i,
  output logic                                                   mem_resp_yumi_o,
  // invalidation request
  input  logic                                                   inv_v_i,
  input  logic [cce_msg_pkg::PADDR_W-1:0]                        inv_addr_i,
  input  logic [cce_msg_pkg::LCE_ID_W-1:0]                       inv_req_lce_i,
  input  logic [cce_msg_pkg::NUM_LCE-1:0]                        sharers_hits_i,
  input  logic [cce_msg_pkg::NUM_LCE-1:0][cce_msg_pkg::WAY_W-1:0] sharers_ways_i,
  output cce_msg_pkg::cce_mode_e                                 cce_mode_o,
  output logic                                                   busy_o
);

  import cce_msg_pkg::*;

  logic                credit_free;
  logic                inv_grant;
  logic                inv_cmd_v;
  logic [LCE_ID_W-1:0] inv_dst;
  logic [WAY_W-1:0]    inv_way;
  logic [PADDR_W-1:0]  inv_cmd_addr;

  // sent commands and popped responses drive the credit count
  cce_mode_ctrl u_mode_ctrl (
    .clk_i(clk_i), .reset_i(reset_i), .cfg_mode_i(cfg_mode_i),
    .mem_cmd_sent_i(mem_cmd_v_o), .mem_resp_pop_i(mem_resp_yumi_o),
    .mode_o(cce_mode_o), .credit_free_o(credit_free)
  );

  cce_req_issue u_req_issue (
    .mode_i(cce_mode_o), .cfg_mode_i(cfg_mode_i), .credit_free_i(credit_free),
    .lce_req_v_i(lce_req_v_i), .lce_req_type_i(lce_req_type_i),
    .lce_req_src_i(lce_req_src_i), .lce_req_addr_i(lce_req_addr_i),
    .lce_req_size_i(lce_req_size_i), .lce_req_data_i(lce_req_data_i),
    .lce_req_yumi_o(lce_req_yumi_o), .mem_cmd_v_o(mem_cmd_v_o),
    .mem_cmd_type_o(mem_cmd_type_o), .mem_cmd_addr_o(mem_cmd_addr_o),
    .mem_cmd_size_o(mem_cmd_size_o), .mem_cmd_lce_id_o(mem_cmd_lce_id_o),
    .mem_cmd_uncached_o(mem_cmd_uncached_o), .mem_cmd_data_o(mem_cmd_data_o),
    .mem_cmd_ready_i(mem_cmd_ready_i)
  );

  cce_resp_forward u_resp_forward (
    .mode_i(cce_mode_o), .cce_id_i(cce_id_i), .mem_resp_v_i(mem_resp_v_i),
    .mem_resp_type_i(mem_resp_type_i), .mem_resp_addr_i(mem_resp_addr_i),
    .mem_resp_size_i(mem_resp_size_i), .mem_resp_lce_id_i(mem_resp_lce_id_i),
    .mem_resp_way_i(mem_resp_way_i), .mem_resp_state_i(mem_resp_state_i),
    .mem_resp_data_i(mem_resp_data_i), .mem_resp_yumi_o(mem_resp_yumi_o),
    .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_type_o(lce_cmd_type_o),
    .lce_cmd_dst_o(lce_cmd_dst_o), .lce_cmd_src_o(lce_cmd_src_o),
    .lce_cmd_addr_o(lce_cmd_addr_o), .lce_cmd_size_o(lce_cmd_size_o),
    .lce_cmd_way_o(lce_cmd_way_o), .lce_cmd_state_o(lce_cmd_state_o),
    .lce_cmd_data_o(lce_cmd_data_o), .lce_cmd_ready_i(lce_cmd_ready_i),
    .inv_cmd_v_i(inv_cmd_v), .inv_dst_i(inv_dst), .inv_way_i(inv_way),
    .inv_addr_i(inv_cmd_addr), .inv_grant_o(inv_grant)
  );

  // lce_resp_src_i is part of the LCE response port, acks are counted, not matched
  cce_inv_engine u_inv_engine (
    .clk_i(clk_i), .reset_i(reset_i), .mode_i(cce_mode_o), .inv_v_i(inv_v_i),
    .inv_addr_i(inv_addr_i), .inv_req_lce_i(inv_req_lce_i),
    .sharers_hits_i(sharers_hits_i), .sharers_ways_i(sharers_ways_i),
    .inv_grant_i(inv_grant), .lce_resp_v_i(lce_resp_v_i),
    .lce_resp_type_i(lce_resp_type_i), .inv_cmd_v_o(inv_cmd_v), .inv_dst_o(inv_dst),
    .inv_way_o(inv_way), .inv_addr_o(inv_cmd_addr), .lce_resp_yumi_o(lce_resp_yumi_o),
    .busy_o(busy_o)
  );

endmodule

//--- testbench/cce_msg_sva.sv
// concurrent assertions bound to the CCE message top level
// command port handshake, uncached issue rule, credit limit
`timescale 1ns/1ps

module cce_msg_sva (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   lce_cmd_v_o,
  input logic                   lce_cmd_ready_i,
  input logic                   lce_req_yumi_o,
  input logic                   mem_cmd_v_o,
  input logic                   mem_cmd_uncached_o,
  input logic                   mem_resp_yumi_o,
  input cce_msg_pkg::cce_mode_e cce_mode_o
);

  import cce_msg_pkg::*;

  // shadow of the outstanding memory response count
  int unsigned shadow_cnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      shadow_cnt <= 0;
    end else if (mem_cmd_v_o & ~mem_resp_yumi_o) begin
      shadow_cnt <= shadow_cnt + 1;
    end else if (mem_resp_yumi_o & ~mem_cmd_v_o) begin
      shadow_cnt <= shadow_cnt - 1;
    end
  end

  a_cmd_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_v_o |-> lce_cmd_ready_i) else $error("lce_cmd_v_o without ready");

  // in uncached mode a popped request leaves only as an uncached command
  a_uc_pop_sends: assert property (@(posedge clk_i) disable iff (reset_i)
    (lce_req_yumi_o && cce_mode_o == e_cce_mode_uncached) |->
    (mem_cmd_v_o && mem_cmd_uncached_o))
    else $error("request popped without uncached memory command");

  a_credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    shadow_cnt <= MEM_CREDITS) else $error("credit count above limit");

endmodule

bind cce_msg_top cce_msg_sva u_sva (
  .clk_i(clk_i), .reset_i(reset_i), .lce_cmd_v_o(lce_cmd_v_o),
  .lce_cmd_ready_i(lce_cmd_ready_i), .lce_req_yumi_o(lce_req_yumi_o),
  .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_uncached_o(mem_cmd_uncached_o),
  .mem_resp_yumi_o(mem_resp_yumi_o), .cce_mode_o(cce_mode_o)
);

//--- testbench/tb_cce_msg.sv
// testbench for the CCE message unit
// random ready/valid models, reference functions, compare process and timeout
`timescale 1ns/1ps

module tb_cce_msg;

  import cce_msg_pkg::*;

  typedef struct packed {
    mem_msg_e             mtype;
    logic [PADDR_W-1:0]   addr;
    logic [SIZE_W-1:0]    size;
    logic [LCE_ID_W-1:0]  lce_id;
    logic                 uncached;
    logic [BLOCK_W-1:0]   data;
  } mem_cmd_t;

  typedef struct packed {
    lce_cmd_e             ctype;
    logic [LCE_ID_W-1:0]  dst;
    logic [CCE_ID_W-1:0]  src;
    logic [PADDR_W-1:0]   addr;
    logic [SIZE_W-1:0]    size;
    logic [WAY_W-1:0]     way;
    coh_state_e           state;
    logic [BLOCK_W-1:0]   data;
  } lce_cmd_t;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  cce_mode_e cfg_mode_i = e_cce_mode_uncached;
  logic [CCE_ID_W-1:0] cce_id_i = 2'd2;
  logic lce_req_v_i = 0;
  logic lce_req_yumi_o;
  lce_req_e lce_req_type_i = e_lce_req_uc_rd;
  logic [LCE_ID_W-1:0] lce_req_src_i = 0;
  logic [PADDR_W-1:0] lce_req_addr_i = 0;
  logic [SIZE_W-1:0] lce_req_size_i = 0;
  logic [BLOCK_W-1:0] lce_req_data_i = 0;
  logic lce_resp_v_i = 0;
  logic lce_resp_yumi_o;
  lce_resp_e lce_resp_type_i = e_lce_resp_inv_ack;
  logic [LCE_ID_W-1:0] lce_resp_src_i = 0;
  logic lce_cmd_v_o;
  logic lce_cmd_ready_i = 0;
  lce_cmd_e lce_cmd_type_o;
  logic [LCE_ID_W-1:0] lce_cmd_dst_o;
  logic [CCE_ID_W-1:0] lce_cmd_src_o;
  logic [PADDR_W-1:0] lce_cmd_addr_o;
  logic [SIZE_W-1:0] lce_cmd_size_o;
  logic [WAY_W-1:0] lce_cmd_way_o;
  coh_state_e lce_cmd_state_o;
  logic [BLOCK_W-1:0] lce_cmd_data_o;
  logic mem_cmd_v_o;
  logic mem_cmd_uncached_o;
  logic mem_cmd_ready_i = 0;
  mem_msg_e mem_cmd_type_o;
  logic [PADDR_W-1:0] mem_cmd_addr_o;
  logic [SIZE_W-1:0] mem_cmd_size_o;
  logic [LCE_ID_W-1:0] mem_cmd_lce_id_o;
  logic [BLOCK_W-1:0] mem_cmd_data_o;
  logic mem_resp_v_i = 0;
  logic mem_resp_yumi_o;
  mem_msg_e mem_resp_type_i = e_mem_msg_uc_rd;
  logic [PADDR_W-1:0] mem_resp_addr_i = 0;
  logic [SIZE_W-1:0] mem_resp_size_i = 0;
  logic [LCE_ID_W-1:0] mem_resp_lce_id_i = 0;
  logic [WAY_W-1:0] mem_resp_way_i = 0;
  coh_state_e mem_resp_state_i = e_coh_i;
  logic [BLOCK_W-1:0] mem_resp_data_i = 0;
  logic inv_v_i = 0;
  logic [PADDR_W-1:0] inv_addr_i = 0;
  logic [LCE_ID_W-1:0] inv_req_lce_i = 0;
  logic [NUM_LCE-1:0] sharers_hits_i = 0;
  logic [NUM_LCE-1:0][WAY_W-1:0] sharers_ways_i = '0;
  cce_mode_e cce_mode_o;
  logic busy_o;

  // scoreboard state
  cce_mode_e exp_mode;
  int out_cnt;
  int pending_acks;
  int cycles;
  int err_cnt;
  logic run_done = 1'b0;
  lce_cmd_t inv_q[$];
  lce_cmd_t exp_lce;

  cce_msg_top UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic mem_cmd_t expect_mem_cmd(lce_req_e t, logic [LCE_ID_W-1:0] src,
      logic [PADDR_W-1:0] addr, logic [SIZE_W-1:0] size, logic [BLOCK_W-1:0] data);
    mem_cmd_t m;
    m = '{mtype: e_mem_msg_uc_rd, addr: addr, size: size, lce_id: src, uncached: 1'b1,
          data: '0};
    if (t == e_lce_req_uc_wr) begin
      m.mtype = e_mem_msg_uc_wr;
      m.data  = data;
    end else if (t == e_lce_req_rd) begin
      // cached fills are block aligned
      m.mtype    = e_mem_msg_rd;
      m.addr     = addr & ~((PADDR_W'(1) << LG_BLOCK_BYTES) - 1);
      m.uncached = 1'b0;
    end
    return m;
  endfunction

  function automatic lce_cmd_t expect_lce_cmd(mem_msg_e t, logic [PADDR_W-1:0] addr,
      logic [SIZE_W-1:0] size, logic [LCE_ID_W-1:0] id, logic [WAY_W-1:0] way,
      coh_state_e st, logic [BLOCK_W-1:0] data, logic [CCE_ID_W-1:0] cce_id);
    lce_cmd_t c;
    c = '{ctype: e_lce_cmd_uc_data, dst: id, src: cce_id, addr: addr, size: size,
          way: '0, state: e_coh_i, data: data};
    if (t == e_mem_msg_uc_wr) begin
      // store done has no payload
      c.ctype = e_lce_cmd_uc_st_done;
      c.size  = '0;
      c.data  = '0;
    end else if (t == e_mem_msg_rd) begin
      c.ctype = e_lce_cmd_data;
      c.way   = way;
      c.state = st;
    end
    return c;
  endfunction

  task automatic fail(string msg);
    err_cnt++;
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_mem_cmd(mem_cmd_t got, mem_cmd_t exp);
    if (got !== exp) begin
      fail($sformatf("ERROR @%0t: mem_cmd got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_lce_cmd(lce_cmd_t got, lce_cmd_t exp);
    if (got !== exp) begin
      fail($sformatf("ERROR @%0t: lce_cmd got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_mode(cce_mode_e got, cce_mode_e exp);
    if (got !== exp) begin
      fail($sformatf("ERROR @%0t: cce_mode_o got %0d expected %0d", $time, got, exp));
    end
  endtask

  // random ready on both output ports, acks only for sent invalidates
  always @(negedge clk_i) begin
    mem_cmd_ready_i = ($urandom_range(0, 3) != 0);
    lce_cmd_ready_i = ($urandom_range(0, 3) != 0);
    lce_resp_v_i    = (pending_acks > 0) && ($urandom_range(0, 1) == 1);
  end

  // compare process, samples values settled since the falling edge
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 20000) begin
      fail("timeout, the run did not finish within 20000 cycles");
    end
    if (reset_i) begin
      exp_mode = e_cce_mode_uncached;
      out_cnt  = 0;
    end else begin
      check_mode(cce_mode_o, exp_mode);
      if (mem_cmd_v_o) begin
        check_mem_cmd({mem_cmd_type_o, mem_cmd_addr_o, mem_cmd_size_o, mem_cmd_lce_id_o,
                       mem_cmd_uncached_o, mem_cmd_data_o},
                      expect_mem_cmd(lce_req_type_i, lce_req_src_i, lce_req_addr_i,
                                     lce_req_size_i, lce_req_data_i));
      end
      if (lce_cmd_v_o) begin
        if (lce_cmd_type_o == e_lce_cmd_inv) begin
          if (inv_q.size() == 0) begin
            fail("an invalidate was sent that was not expected");
          end
          exp_lce = inv_q.pop_front();
          pending_acks++;
        end else begin
          exp_lce = expect_lce_cmd(mem_resp_type_i, mem_resp_addr_i, mem_resp_size_i,
                                   mem_resp_lce_id_i, mem_resp_way_i, mem_resp_state_i,
                                   mem_resp_data_i, cce_id_i);
        end
        check_lce_cmd({lce_cmd_type_o, lce_cmd_dst_o, lce_cmd_src_o, lce_cmd_addr_o,
                       lce_cmd_size_o, lce_cmd_way_o, lce_cmd_state_o, lce_cmd_data_o},
                      exp_lce);
      end
      if (lce_resp_yumi_o) begin
        pending_acks--;
      end
      // mode register loads only with nothing outstanding
      if (out_cnt == 0) begin
        exp_mode = cfg_mode_i;
      end
      out_cnt = out_cnt + int'(mem_cmd_v_o) - int'(mem_resp_yumi_o);
      if (out_cnt > MEM_CREDITS) begin
        fail("more memory commands outstanding than the credit limit");
      end
    end
  end

  task automatic send_req(lce_req_e t);
    @(negedge clk_i);
    lce_req_type_i = t;
    lce_req_src_i  = LCE_ID_W'($urandom);
    lce_req_addr_i = $urandom;
    lce_req_size_i = SIZE_W'($urandom);
    lce_req_data_i = {$urandom, $urandom};
    lce_req_v_i    = 1'b1;
    @(posedge clk_i);
    while (!lce_req_yumi_o) @(posedge clk_i);
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  task automatic send_resp(mem_msg_e t);
    @(negedge clk_i);
    mem_resp_type_i   = t;
    mem_resp_addr_i   = $urandom;
    mem_resp_size_i   = SIZE_W'($urandom);
    mem_resp_lce_id_i = LCE_ID_W'($urandom);
    mem_resp_way_i    = WAY_W'($urandom);
    mem_resp_state_i  = coh_state_e'($urandom_range(0, 3));
    mem_resp_data_i   = {$urandom, $urandom};
    mem_resp_v_i      = 1'b1;
    @(posedge clk_i);
    while (!mem_resp_yumi_o) @(posedge clk_i);
    @(negedge clk_i);
    mem_resp_v_i = 1'b0;
  endtask

  // holds a request and expects it to stay un-popped
  task automatic hold_req(lce_req_e t, int n);
    @(negedge clk_i);
    lce_req_type_i = t;
    lce_req_v_i    = 1'b1;
    repeat (n) begin
      @(posedge clk_i);
      if (lce_req_yumi_o) begin
        fail("a request was popped while it should stall");
      end
    end
  endtask

  task automatic run_inv(logic [NUM_LCE-1:0] hits, logic [LCE_ID_W-1:0] req);
    lce_cmd_t c;
    @(negedge clk_i);
    inv_addr_i     = $urandom;
    inv_req_lce_i  = req;
    sharers_hits_i = hits;
    sharers_ways_i = (NUM_LCE * WAY_W)'($urandom);
    for (int i = 0; i < NUM_LCE; i++) begin
      if (hits[i] && LCE_ID_W'(i) != req) begin
        c = '{ctype: e_lce_cmd_inv, dst: LCE_ID_W'(i), src: cce_id_i, addr: inv_addr_i,
              size: '0, way: sharers_ways_i[i], state: e_coh_i, data: '0};
        inv_q.push_back(c);
      end
    end
    inv_v_i = 1'b1;
    @(negedge clk_i);
    inv_v_i = 1'b0;
    if (!busy_o) begin
      fail("busy did not rise after an invalidation strobe");
    end
    while (busy_o) @(posedge clk_i);
    if (inv_q.size() != 0 || pending_acks != 0) begin
      fail("busy fell before all invalidates were sent and acknowledged");
    end
  endtask

  // run stopped early by a bound assertion
  final begin
    if (!run_done && err_cnt == 0) begin
      $display("*** TEST FAILED ***");
    end
  end

  initial begin
    void'($urandom(54));
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (3) begin
      @(posedge clk_i);
      if (mem_cmd_v_o | lce_cmd_v_o | lce_req_yumi_o | mem_resp_yumi_o | lce_resp_yumi_o |
          busy_o) begin
        fail("an output was active right after reset");
      end
    end
    // uncached traffic, cached read must stall
    send_req(e_lce_req_uc_rd);
    send_req(e_lce_req_uc_wr);
    send_resp(e_mem_msg_uc_rd);
    send_resp(e_mem_msg_uc_wr);
    hold_req(e_lce_req_rd, 6);
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
    // fill the credits, the fifth waits for a response pop
    repeat (MEM_CREDITS) send_req(e_lce_req_uc_wr);
    hold_req(e_lce_req_uc_rd, 8);
    send_resp(e_mem_msg_uc_rd);
    @(posedge clk_i);
    while (!lce_req_yumi_o) @(posedge clk_i);
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
    // request normal mode while four responses are outstanding
    cfg_mode_i = e_cce_mode_normal;
    repeat (2) send_resp(e_mem_msg_uc_wr);
    repeat (2) send_resp(e_mem_msg_uc_rd);
    while (cce_mode_o != e_cce_mode_normal) @(posedge clk_i);
    send_req(e_lce_req_rd);
    send_resp(e_mem_msg_rd);
    run_inv(4'b1011, 2'd1);
    run_inv(4'b1111, 2'd3);
    run_inv(4'b0100, 2'd2);
    run_inv(NUM_LCE'($urandom), LCE_ID_W'($urandom));
    repeat (4) @(posedge clk_i);
    run_done = 1'b1;
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- cce_msg.f
verilog/cce_msg_pkg.sv
verilog/cce_mode_ctrl.sv
verilog/cce_req_issue.sv
verilog/cce_resp_forward.sv
verilog/cce_inv_engine.sv
verilog/cce_msg_top.sv
testbench/cce_msg_sva.sv
testbench/tb_cce_msg.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_cce_msg -f cce_msg.f

sim:
	verilator --binary --timing --assert --top-module tb_cce_msg -f cce_msg.f -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
